// File: hw/i2c_master_macros.svh
// **********************************************************
// I2C master register map, command and control bit fields,
// and register reset values
// **********************************************************

`ifndef I2C_MASTER_MACROS_SVH
`define I2C_MASTER_MACROS_SVH

// Register offsets on the processor bus
`define I2C_ADR_PRER_LO 8'h00
`define I2C_ADR_PRER_HI 8'h04
`define I2C_ADR_CTRL    8'h08
`define I2C_ADR_DATA    8'h0c
`define I2C_ADR_CMDSTAT 8'h10

// Command register bit positions
`define I2C_CMD_STA  7
`define I2C_CMD_STO  6
`define I2C_CMD_RD   5
`define I2C_CMD_WR   4
`define I2C_CMD_ACK  3
`define I2C_CMD_IACK 0

// Control register bit positions
`define I2C_CTRL_EN  7
`define I2C_CTRL_IEN 6

// Prescale comes out of reset at the slowest rate
`define I2C_PRER_RST 16'hffff

`endif

// File: hw/i2c_master_pkg.sv
// **********************************************************
// I2C master shared types: bus widths and FSM state encodings
// **********************************************************

package i2c_master_pkg;

	typedef logic [7:0]  reg_addr_t;
	typedef logic [7:0]  data_byte_t;
	typedef logic [15:0] prescale_t;

	// Byte controller sequencing
	typedef enum logic [2:0] {
		BYTE_IDLE,
		BYTE_START,
		BYTE_READ,
		BYTE_WRITE,
		BYTE_ACK,
		BYTE_STOP
	} byte_state_t;

	// Operations handed to the bit controller
	typedef enum logic [2:0] {
		CMD_NOP,
		CMD_START,
		CMD_STOP,
		CMD_WRITE,
		CMD_READ
	} bit_cmd_t;

	// Quarter phases of one SCL period
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_A,
		PH_B,
		PH_C,
		PH_D
	} bit_state_t;

endpackage

// File: hw/i2c_cmd_if.sv
// **********************************************************
// Command bus between register block, byte and bit controllers
// **********************************************************

interface i2c_cmd_if import i2c_master_pkg::*; ();

	// Byte level request and response
	logic       start, stop, read, write, ack_in, core_en;
	data_byte_t tx_byte;
	prescale_t  prescale;
	logic       done, rx_ack, busy;
	data_byte_t rx_byte;

	// Bit level request and response
	bit_cmd_t   bit_cmd;
	logic       bit_din;
	logic       bit_ack, bit_dout, bit_busy;

	modport regs_mp (
		output start, stop, read, write, ack_in, tx_byte, core_en, prescale,
		input  done, rx_ack, rx_byte, busy
	);

	modport byte_req_mp (
		input  start, stop, read, write, ack_in, tx_byte, core_en,
		output done, rx_ack, rx_byte, busy
	);

	modport byte_bit_mp (
		output bit_cmd, bit_din,
		input  bit_ack, bit_dout, bit_busy
	);

	modport bit_mp (
		input  bit_cmd, bit_din, prescale, core_en,
		output bit_ack, bit_dout, bit_busy
	);

endinterface

// File: hw/i2c_master_regs.sv
// **********************************************************
// I2C master register block: processor bus slave, command and
// status registers, interrupt flag and registered irq
// **********************************************************

`include "i2c_master_macros.svh"

module i2c_master_regs
	import i2c_master_pkg::*;
(
	input  logic       rvx_port_07,
	input  logic       rvx_port_00,
	input  logic       bus_cyc,
	input  logic       bus_stb,
	input  logic       bus_we,
	input  reg_addr_t  bus_adr,
	input  data_byte_t bus_wdat,
	output data_byte_t bus_rdat,
	output logic       bus_ack,
	output logic       irq,
	i2c_cmd_if.regs_mp cmd
);

	logic       bus_req, bus_req_d, bus_acc, bus_wr;
	prescale_t  prer;
	data_byte_t ctrl, txr, cr, status;
	logic       tip, irq_flag;
	logic       cmd_pending, cmd_wr;

	// **********************************************************
	// Bus handshake
	// **********************************************************

	// One acknowledge per request, taken on its first cycle
	assign bus_req = bus_cyc & bus_stb;
	assign bus_acc = bus_req & ~bus_req_d;
	assign bus_wr  = bus_acc & bus_we;

	always_ff @(posedge rvx_port_07 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
		begin
			bus_req_d <= 1'b0;
			bus_ack   <= 1'b0;
		end
		else
		begin
			bus_req_d <= bus_req;
			bus_ack   <= bus_acc;
		end
	end

	// Plain read/write registers
	always_ff @(posedge rvx_port_07 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
		begin
			prer <= `I2C_PRER_RST;
			ctrl <= '0;
			txr  <= '0;
		end
		else if (bus_wr)
		begin
			case (bus_adr)
				`I2C_ADR_PRER_LO: prer[7:0]  <= bus_wdat;
				`I2C_ADR_PRER_HI: prer[15:8] <= bus_wdat;
				`I2C_ADR_CTRL:    ctrl       <= bus_wdat;
				`I2C_ADR_DATA:    txr        <= bus_wdat;
				default: ;
			endcase
		end
	end

	// **********************************************************
	// Command register
	// **********************************************************

	assign cmd_pending = cr[`I2C_CMD_RD] | cr[`I2C_CMD_WR] | cr[`I2C_CMD_STO];

	// New commands only when the core is on and nothing is in flight
	assign cmd_wr = bus_wr & (bus_adr == `I2C_ADR_CMDSTAT) & ctrl[`I2C_CTRL_EN] &
		~cmd_pending & ~tip;

	always_ff @(posedge rvx_port_07 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
			cr <= '0;
		else if (cmd_wr)
			cr <= bus_wdat;
		else
		begin
			// A start alone has nothing to run, so it is dropped as well
			if (cmd.done | ~cmd_pending | ~ctrl[`I2C_CTRL_EN])
				cr[7:4] <= 4'h0;
			cr[2:0] <= 3'h0;
		end
	end

	// Transfer in progress, interrupt flag and irq
	always_ff @(posedge rvx_port_07 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
		begin
			tip      <= 1'b0;
			irq_flag <= 1'b0;
			irq      <= 1'b0;
		end
		else
		begin
			tip      <= cmd_pending & ~cmd.done;
			irq_flag <= (irq_flag | cmd.done) & ~cr[`I2C_CMD_IACK];
			irq      <= irq_flag & ctrl[`I2C_CTRL_IEN];
		end
	end

	assign cmd.start    = cr[`I2C_CMD_STA];
	assign cmd.stop     = cr[`I2C_CMD_STO];
	assign cmd.read     = cr[`I2C_CMD_RD];
	assign cmd.write    = cr[`I2C_CMD_WR];
	assign cmd.ack_in   = cr[`I2C_CMD_ACK];
	assign cmd.tx_byte  = txr;
	assign cmd.core_en  = ctrl[`I2C_CTRL_EN];
	assign cmd.prescale = prer;

	// Bit 5 is arbitration lost, which this core never reports
	assign status = {cmd.rx_ack, cmd.busy, 1'b0, 3'b000, tip, irq_flag};

	// Read data mux
	always_comb
	begin
		case (bus_adr)
			`I2C_ADR_PRER_LO: bus_rdat = prer[7:0];
			`I2C_ADR_PRER_HI: bus_rdat = prer[15:8];
			`I2C_ADR_CTRL:    bus_rdat = ctrl;
			`I2C_ADR_DATA:    bus_rdat = cmd.rx_byte;
			`I2C_ADR_CMDSTAT: bus_rdat = status;
			default:          bus_rdat = '0;
		endcase
	end

endmodule

// File: hw/i2c_byte_ctrl.sv
// **********************************************************
// I2C byte controller: expands one command into start, eight
// data bits, acknowledge and stop bit operations
// **********************************************************

module i2c_byte_ctrl
	import i2c_master_pkg::*;
(
	input logic            rvx_port_07,
	input logic            rvx_port_00,
	i2c_cmd_if.byte_req_mp req,
	i2c_cmd_if.byte_bit_mp bitc
);

	byte_state_t state;
	bit_cmd_t    cmd_q;
	data_byte_t  sr;
	data_byte_t  rx_q;
	logic [2:0]  bit_cnt;
	logic        din_q, done_q, rx_ack_q;
	logic        go;

	// Flags are still set during the done cycle, so ignore them then
	assign go = (req.read | req.write | req.stop) & ~done_q;

	assign bitc.bit_cmd = cmd_q;
	assign bitc.bit_din = din_q;
	assign req.done     = done_q;
	assign req.rx_ack   = rx_ack_q;
	assign req.rx_byte  = rx_q;
	assign req.busy     = bitc.bit_busy;

	always_ff @(posedge rvx_port_07 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
		begin
			state    <= BYTE_IDLE;
			cmd_q    <= CMD_NOP;
			sr       <= '0;
			rx_q     <= '0;
			bit_cnt  <= '0;
			din_q    <= 1'b0;
			done_q   <= 1'b0;
			rx_ack_q <= 1'b0;
		end
		else if (!req.core_en)
		begin
			state  <= BYTE_IDLE;
			cmd_q  <= CMD_NOP;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			case (state)
				BYTE_IDLE:
					if (go)
					begin
						sr      <= req.tx_byte;
						bit_cnt <= 3'd7;
						if (req.start)
						begin
							state <= BYTE_START;
							cmd_q <= CMD_START;
						end
						else if (req.read)
						begin
							state <= BYTE_READ;
							cmd_q <= CMD_READ;
						end
						else if (req.write)
						begin
							state <= BYTE_WRITE;
							cmd_q <= CMD_WRITE;
							din_q <= req.tx_byte[7];
						end
						else
						begin
							state <= BYTE_STOP;
							cmd_q <= CMD_STOP;
						end
					end
				BYTE_START:
					if (bitc.bit_ack)
					begin
						if (req.read)
						begin
							state <= BYTE_READ;
							cmd_q <= CMD_READ;
						end
						else
						begin
							state <= BYTE_WRITE;
							cmd_q <= CMD_WRITE;
							din_q <= sr[7];
						end
					end
				BYTE_READ, BYTE_WRITE:
					if (bitc.bit_ack)
					begin
						// MSB first; every bit is sampled back from SDA
						sr <= {sr[6:0], bitc.bit_dout};
						if (bit_cnt == 3'd0)
						begin
							state <= BYTE_ACK;
							if (req.read)
							begin
								cmd_q <= CMD_WRITE;
								din_q <= req.ack_in;
							end
							else
								cmd_q <= CMD_READ;
						end
						else
						begin
							bit_cnt <= bit_cnt - 3'd1;
							din_q   <= sr[6];
						end
					end
				BYTE_ACK:
					if (bitc.bit_ack)
					begin
						rx_ack_q <= bitc.bit_dout;
						if (req.read)
							rx_q <= sr;
						if (req.stop)
						begin
							state <= BYTE_STOP;
							cmd_q <= CMD_STOP;
						end
						else
						begin
							state  <= BYTE_IDLE;
							cmd_q  <= CMD_NOP;
							done_q <= 1'b1;
						end
					end
				BYTE_STOP:
					if (bitc.bit_ack)
					begin
						state  <= BYTE_IDLE;
						cmd_q  <= CMD_NOP;
						done_q <= 1'b1;
					end
				default:
					state <= BYTE_IDLE;
			endcase
		end
	end

endmodule

// File: hw/i2c_bit_ctrl.sv
// **********************************************************
// I2C bit controller: prescaled quarter phases driving SCL and
// SDA, read sampling and bus start/stop detection
// **********************************************************

module i2c_bit_ctrl
	import i2c_master_pkg::*;
(
	input  logic       rvx_port_07,
	input  logic       rvx_port_00,
	i2c_cmd_if.bit_mp  bitc,
	input  logic       scl_in,
	input  logic       sda_in,
	output logic       scl_out,
	output logic       scl_oe_n,
	output logic       sda_out,
	output logic       sda_oe_n
);

	bit_state_t state, next_phase;
	prescale_t  cnt;
	logic [1:0] scl_sync, sda_sync;
	logic       scl_s, sda_s, sda_prev;
	logic       start_det, stop_det;
	logic       scl_rel, sda_rel;
	logic       ack_q, dout_q, busy_q;
	logic       go, step, load;

	// **********************************************************
	// Line synchronizers and bus condition detection
	// **********************************************************

	always_ff @(posedge rvx_port_07 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
		begin
			scl_sync <= 2'b11;
			sda_sync <= 2'b11;
			sda_prev <= 1'b1;
			busy_q   <= 1'b0;
		end
		else
		begin
			scl_sync <= {scl_sync[0], scl_in};
			sda_sync <= {sda_sync[0], sda_in};
			sda_prev <= sda_s;
			busy_q   <= (busy_q | start_det) & ~stop_det;
		end
	end

	assign scl_s     = scl_sync[1];
	assign sda_s     = sda_sync[1];
	// SDA edges while SCL is high
	assign start_det = scl_s & sda_prev & ~sda_s;
	assign stop_det  = scl_s & ~sda_prev & sda_s;

	// **********************************************************
	// Quarter phase sequencer
	// **********************************************************

	// Ack cycle still shows the old command, so wait one cycle
	assign go   = (state == PH_IDLE) & (bitc.bit_cmd != CMD_NOP) & ~ack_q;
	assign step = (state != PH_IDLE) & (cnt == '0);
	assign load = go | (step & (state != PH_D));

	always_comb
	begin
		case (state)
			PH_IDLE: next_phase = PH_A;
			PH_A:    next_phase = PH_B;
			PH_B:    next_phase = PH_C;
			PH_C:    next_phase = PH_D;
			default: next_phase = PH_IDLE;
		endcase
	end

	always_ff @(posedge rvx_port_07 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
		begin
			state  <= PH_IDLE;
			cnt    <= '0;
			ack_q  <= 1'b0;
			dout_q <= 1'b0;
		end
		else if (!bitc.core_en)
		begin
			state <= PH_IDLE;
			cnt   <= '0;
			ack_q <= 1'b0;
		end
		else
		begin
			ack_q <= 1'b0;
			if (go | step)
			begin
				state <= next_phase;
				cnt   <= bitc.prescale;
				// SCL has been high through B and C
				if (state == PH_C)
					dout_q <= sda_s;
				if (state == PH_D)
					ack_q <= 1'b1;
			end
			else if (state != PH_IDLE)
				cnt <= cnt - 16'd1;
		end
	end

	// Line levels for the phase being entered, 1 releases the line
	always_ff @(posedge rvx_port_07 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
		begin
			scl_rel <= 1'b1;
			sda_rel <= 1'b1;
		end
		else if (!bitc.core_en)
		begin
			scl_rel <= 1'b1;
			sda_rel <= 1'b1;
		end
		else if (load)
		begin
			case (bitc.bit_cmd)
				CMD_START:
				begin
					// Phase A keeps SCL, so a repeated start begins with SCL low
					if (next_phase != PH_A)
						scl_rel <= (next_phase != PH_D);
					sda_rel <= (next_phase == PH_A) | (next_phase == PH_B);
				end
				CMD_STOP:
				begin
					scl_rel <= (next_phase != PH_A);
					sda_rel <= (next_phase == PH_D);
				end
				CMD_WRITE:
				begin
					scl_rel <= (next_phase == PH_B) | (next_phase == PH_C);
					sda_rel <= bitc.bit_din;
				end
				CMD_READ:
				begin
					scl_rel <= (next_phase == PH_B) | (next_phase == PH_C);
					sda_rel <= 1'b1;
				end
				default: ;
			endcase
		end
	end

	// Open drain: outputs stay low, enables do the work
	assign scl_out  = 1'b0;
	assign sda_out  = 1'b0;
	assign scl_oe_n = scl_rel;
	assign sda_oe_n = sda_rel;

	assign bitc.bit_ack  = ack_q;
	assign bitc.bit_dout = dout_q;
	assign bitc.bit_busy = busy_q;

endmodule

// File: hw/i2c_master.sv
// **********************************************************
// I2C master top: register block, byte and bit controllers
// **********************************************************

module i2c_master
	import i2c_master_pkg::*;
(
	input  logic       rvx_port_07,
	input  logic       rvx_port_00,
	input  logic       bus_cyc,
	input  logic       bus_stb,
	input  logic       bus_we,
	input  reg_addr_t  bus_adr,
	input  data_byte_t bus_wdat,
	output data_byte_t bus_rdat,
	output logic       bus_ack,
	output logic       irq,
	input  logic       scl_in,
	input  logic       sda_in,
	output logic       scl_out,
	output logic       scl_oe_n,
	output logic       sda_out,
	output logic       sda_oe_n
);

	i2c_cmd_if cmd_bus ();

	i2c_master_regs u_regs (
		.rvx_port_07 (rvx_port_07),
		.rvx_port_00 (rvx_port_00),
		.bus_cyc     (bus_cyc),
		.bus_stb     (bus_stb),
		.bus_we      (bus_we),
		.bus_adr     (bus_adr),
		.bus_wdat    (bus_wdat),
		.bus_rdat    (bus_rdat),
		.bus_ack     (bus_ack),
		.irq         (irq),
		.cmd         (cmd_bus)
	);

	// Same interface instance serves both sides of the byte controller
	i2c_byte_ctrl u_byte_ctrl (
		.rvx_port_07 (rvx_port_07),
		.rvx_port_00 (rvx_port_00),
		.req         (cmd_bus),
		.bitc        (cmd_bus)
	);

	i2c_bit_ctrl u_bit_ctrl (
		.rvx_port_07 (rvx_port_07),
		.rvx_port_00 (rvx_port_00),
		.bitc        (cmd_bus),
		.scl_in      (scl_in),
		.sda_in      (sda_in),
		.scl_out     (scl_out),
		.scl_oe_n    (scl_oe_n),
		.sda_out     (sda_out),
		.sda_oe_n    (sda_oe_n)
	);

endmodule

// File: verification/i2c_slave_model.sv
// **********************************************************
// Behavioral I2C slave with a fixed address, stores the last
// written byte and returns it on reads
// **********************************************************

module i2c_slave_model
	#(parameter logic [6:0] SLAVE_ADDR = 7'h2a)
(
	input  logic       scl,
	input  logic       sda,
	output logic       sda_pull,
	output logic [7:0] last_byte
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int P_IDLE  = 0;
	localparam int P_ADDR  = 1;
	localparam int P_WDATA = 2;
	localparam int P_RDATA = 3;

	int         phase = P_IDLE;
	int         bit_cnt = 0;
	logic [7:0] shreg = '0;
	logic [7:0] txb = '0;
	logic [7:0] wr_byte = '0;
	logic       is_read = 1'b0;
	logic       mack = 1'b1;
	logic       pull_low = 1'b0;
	logic       scl_q = 1'b1;
	logic       sda_q = 1'b1;

	assign sda_pull  = pull_low;
	assign last_byte = wr_byte;

	// Every line edge lands here and is told apart by the last levels seen
	always @(posedge scl or negedge scl or posedge sda or negedge sda)
	begin
		if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q)
		begin
			// Start and stop conditions
			if (sda === 1'b0)
			begin
				phase   = P_ADDR;
				bit_cnt = 0;
			end
			else
				phase = P_IDLE;
			pull_low = 1'b0;
		end
		else if (scl === 1'b1 && scl_q !== 1'b1)
		begin
			// Sample on the rising SCL edge; bit_cnt 9 is the acknowledge slot
			if (phase != P_IDLE)
			begin
				bit_cnt = bit_cnt + 1;
				if (phase != P_RDATA && bit_cnt <= 8)
					shreg = {shreg[6:0], sda};
				if (phase == P_RDATA && bit_cnt == 9)
					mack = sda;
			end
		end
		else if (scl === 1'b0 && scl_q === 1'b1)
		begin
			// Change SDA only while SCL is low
			case (phase)
				P_ADDR:
					if (bit_cnt == 8)
					begin
						if (shreg[7:1] == SLAVE_ADDR)
						begin
							is_read  = shreg[0];
							pull_low = 1'b1;
						end
						else
							phase = P_IDLE;
					end
					else if (bit_cnt == 9)
					begin
						pull_low = 1'b0;
						bit_cnt  = 0;
						if (is_read)
						begin
							phase    = P_RDATA;
							txb      = wr_byte;
							pull_low = ~txb[7];
						end
						else
							phase = P_WDATA;
					end
				P_WDATA:
					if (bit_cnt == 8)
					begin
						wr_byte  = shreg;
						pull_low = 1'b1;
					end
					else if (bit_cnt == 9)
					begin
						pull_low = 1'b0;
						bit_cnt  = 0;
					end
				P_RDATA:
					if (bit_cnt >= 1 && bit_cnt <= 7)
						pull_low = ~txb[7 - bit_cnt];
					else if (bit_cnt == 8)
						pull_low = 1'b0;
					else if (bit_cnt == 9)
					begin
						bit_cnt = 0;
						// Master acknowledge asks for another byte
						if (mack == 1'b0)
							pull_low = ~txb[7];
						else
							phase = P_IDLE;
					end
				default: ;
			endcase
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

// File: verification/i2c_master_tb.sv
// **********************************************************
// I2C master testbench: register bus tasks, slave model and
// a table of bus transactions checked against the slave
// **********************************************************

`include "i2c_master_macros.svh"

module i2c_master_tb
	import i2c_master_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_ROWS = 5;
	localparam int PRESCALE = 4;
	localparam int BIT_CLKS = 4 * (PRESCALE + 1);
	// Two byte commands per row, eleven bit times each, doubled, plus setup
	localparam int CYCLE_LIMIT = NUM_ROWS * 2 * 11 * BIT_CLKS * 2 + 1000;
	localparam logic [6:0] SLAVE_ADDR = 7'h2a;

	localparam data_byte_t C_STA  = data_byte_t'(1) << `I2C_CMD_STA;
	localparam data_byte_t C_STO  = data_byte_t'(1) << `I2C_CMD_STO;
	localparam data_byte_t C_RD   = data_byte_t'(1) << `I2C_CMD_RD;
	localparam data_byte_t C_WR   = data_byte_t'(1) << `I2C_CMD_WR;
	localparam data_byte_t C_ACK  = data_byte_t'(1) << `I2C_CMD_ACK;
	localparam data_byte_t C_IACK = data_byte_t'(1) << `I2C_CMD_IACK;

	logic       clk, rst_n;
	logic       bus_cyc, bus_stb, bus_we;
	reg_addr_t  bus_adr;
	data_byte_t bus_wdat, bus_rdat;
	logic       bus_ack, irq;
	logic       scl_out, scl_oe_n, sda_out, sda_oe_n;
	logic       sda_pull;
	data_byte_t slave_byte;
	wire        scl_line, sda_line;

	int seed = 49916;
	int cycles = 0;

	// Stimulus table
	string      row_name [NUM_ROWS];
	logic [6:0] row_addr [NUM_ROWS];
	logic       row_rd   [NUM_ROWS];
	data_byte_t row_data [NUM_ROWS];
	logic       row_ack  [NUM_ROWS];
	data_byte_t row_rx   [NUM_ROWS];

	// Pull-ups: wired-AND of master and slave
	assign scl_line = scl_oe_n ? 1'b1 : scl_out;
	assign sda_line = (sda_oe_n ? 1'b1 : sda_out) & ~sda_pull;

	i2c_master DUT (
		.rvx_port_07 (clk),
		.rvx_port_00 (rst_n),
		.bus_cyc     (bus_cyc),
		.bus_stb     (bus_stb),
		.bus_we      (bus_we),
		.bus_adr     (bus_adr),
		.bus_wdat    (bus_wdat),
		.bus_rdat    (bus_rdat),
		.bus_ack     (bus_ack),
		.irq         (irq),
		.scl_in      (scl_line),
		.sda_in      (sda_line),
		.scl_out     (scl_out),
		.scl_oe_n    (scl_oe_n),
		.sda_out     (sda_out),
		.sda_oe_n    (sda_oe_n)
	);

	i2c_slave_model #(.SLAVE_ADDR(SLAVE_ADDR)) u_slave (
		.scl       (scl_line),
		.sda       (sda_line),
		.sda_pull  (sda_pull),
		.last_byte (slave_byte)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_fail(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			report_fail("Timeout: the run did not finish within the cycle limit");
	end

	// **********************************************************
	// Compare tasks
	// **********************************************************

	task automatic check_byte(input string name, input data_byte_t exp, input data_byte_t act);
		if (act !== exp)
			report_fail($sformatf("[ERROR] %s: expected %02h, actual %02h", name, exp, act));
	endtask

	task automatic check_ack(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_fail($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_irq(input string name, input logic exp);
		if (irq !== exp)
			report_fail($sformatf("[ERROR] %s irq: expected %b, actual %b", name, exp, irq));
	endtask

	// **********************************************************
	// Register bus and command tasks
	// **********************************************************

	task automatic bus_write(input reg_addr_t adr, input data_byte_t dat);
		@(posedge clk);
		bus_cyc  <= 1'b1;
		bus_stb  <= 1'b1;
		bus_we   <= 1'b1;
		bus_adr  <= adr;
		bus_wdat <= dat;
		do
			@(negedge clk);
		while (bus_ack !== 1'b1);
		@(posedge clk);
		bus_cyc <= 1'b0;
		bus_stb <= 1'b0;
		bus_we  <= 1'b0;
	endtask

	task automatic bus_read(input reg_addr_t adr, output data_byte_t dat);
		@(posedge clk);
		bus_cyc <= 1'b1;
		bus_stb <= 1'b1;
		bus_we  <= 1'b0;
		bus_adr <= adr;
		do
			@(negedge clk);
		while (bus_ack !== 1'b1);
		dat = bus_rdat;
		@(posedge clk);
		bus_cyc <= 1'b0;
		bus_stb <= 1'b0;
	endtask

	// Poll status until transfer in progress clears
	task automatic wait_idle();
		data_byte_t st;
		do
			bus_read(`I2C_ADR_CMDSTAT, st);
		while (st[1]);
	endtask

	// Issue a command, expect irq, then acknowledge the interrupt
	task automatic run_cmd(input string name, input data_byte_t cmd);
		bus_write(`I2C_ADR_CMDSTAT, cmd);
		wait_idle();
		@(posedge clk);
		@(negedge clk);
		check_irq(name, 1'b1);
		bus_write(`I2C_ADR_CMDSTAT, C_IACK);
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_irq({name, " iack"}, 1'b0);
	endtask

	task automatic build_table();
		data_byte_t last;
		row_name[0] = "write_match";
		row_addr[0] = SLAVE_ADDR;
		row_rd[0]   = 1'b0;
		row_name[1] = "write_other";
		row_addr[1] = 7'h15;
		row_rd[1]   = 1'b0;
		row_name[2] = "read_back";
		row_addr[2] = SLAVE_ADDR;
		row_rd[2]   = 1'b1;
		row_name[3] = "write_again";
		row_addr[3] = SLAVE_ADDR;
		row_rd[3]   = 1'b0;
		row_name[4] = "read_again";
		row_addr[4] = SLAVE_ADDR;
		row_rd[4]   = 1'b1;
		last = '0;
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			row_data[i] = data_byte_t'($random(seed));
			row_ack[i]  = (row_addr[i] != SLAVE_ADDR);
			row_rx[i]   = last;
			// The slave keeps the last byte written to it
			if (!row_ack[i] && !row_rd[i])
				last = row_data[i];
		end
	endtask

	// **********************************************************
	// Main sequence
	// **********************************************************

	initial
	begin
		data_byte_t st;
		data_byte_t rx;
		string      nm;
		bus_cyc  = 1'b0;
		bus_stb  = 1'b0;
		bus_we   = 1'b0;
		bus_adr  = '0;
		bus_wdat = '0;
		rst_n    = 1'b0;
		build_table();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// Reset values and register read back
		check_irq("reset", 1'b0);
		check_ack("bus_ack reset", 1'b0, bus_ack);
		check_ack("scl_oe_n reset", 1'b1, scl_oe_n);
		check_ack("sda_oe_n reset", 1'b1, sda_oe_n);
		check_ack("scl_out", 1'b0, scl_out);
		check_ack("sda_out", 1'b0, sda_out);
		bus_read(`I2C_ADR_PRER_LO, rx);
		check_byte("prer_lo reset", 8'hff, rx);
		bus_read(`I2C_ADR_PRER_HI, rx);
		check_byte("prer_hi reset", 8'hff, rx);
		bus_read(`I2C_ADR_CTRL, rx);
		check_byte("ctrl reset", 8'h00, rx);
		bus_write(`I2C_ADR_PRER_LO, data_byte_t'(PRESCALE));
		bus_write(`I2C_ADR_PRER_HI, 8'h00);
		bus_write(`I2C_ADR_CTRL, 8'hc0);
		bus_read(`I2C_ADR_PRER_LO, rx);
		check_byte("prer_lo readback", data_byte_t'(PRESCALE), rx);
		bus_read(`I2C_ADR_PRER_HI, rx);
		check_byte("prer_hi readback", 8'h00, rx);
		bus_read(`I2C_ADR_CTRL, rx);
		check_byte("ctrl readback", 8'hc0, rx);
		bus_read(`I2C_ADR_CMDSTAT, rx);
		check_byte("status idle", 8'h00, rx);

		for (int i = 0; i < NUM_ROWS; i++)
		begin
			nm = row_name[i];
			bus_write(`I2C_ADR_DATA, {row_addr[i], row_rd[i]});
			run_cmd({nm, " addr"}, C_STA | C_WR);
			bus_read(`I2C_ADR_CMDSTAT, st);
			check_ack({nm, " addr ack"}, row_ack[i], st[7]);
			check_ack({nm, " busy"}, 1'b1, st[6]);
			if (row_ack[i])
				run_cmd({nm, " stop"}, C_STO);
			else if (row_rd[i])
			begin
				// No acknowledge on the single read byte
				run_cmd({nm, " read"}, C_RD | C_ACK | C_STO);
				bus_read(`I2C_ADR_DATA, rx);
				check_byte({nm, " rx byte"}, row_rx[i], rx);
			end
			else
			begin
				bus_write(`I2C_ADR_DATA, row_data[i]);
				run_cmd({nm, " data"}, C_WR | C_STO);
				bus_read(`I2C_ADR_CMDSTAT, st);
				check_ack({nm, " data ack"}, 1'b0, st[7]);
				check_byte({nm, " slave byte"}, row_data[i], slave_byte);
			end
			bus_read(`I2C_ADR_CMDSTAT, st);
			check_ack({nm, " busy after stop"}, 1'b0, st[6]);
		end

		// Interrupt enable off: flag sets, irq stays low
		bus_write(`I2C_ADR_CTRL, 8'h80);
		bus_write(`I2C_ADR_CMDSTAT, C_STO);
		wait_idle();
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_irq("irq disabled", 1'b0);
		bus_read(`I2C_ADR_CMDSTAT, st);
		check_ack("irq flag", 1'b1, st[0]);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: i2c_master.f
+incdir+hw
hw/i2c_master_pkg.sv
hw/i2c_cmd_if.sv
hw/i2c_master_regs.sv
hw/i2c_byte_ctrl.sv
hw/i2c_bit_ctrl.sv
hw/i2c_master.sv
verification/i2c_slave_model.sv
verification/i2c_master_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps -Mdir obj_dir
TOP       = i2c_master_tb
FILELIST  = i2c_master.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -F -q "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
